// ==== tcdm_mem_pkg.sv ====
// Memory word package for the shared-memory cluster slice.
// Holds the widths and types of one data word, its byte enables and its address.
package tcdm_mem_pkg;

  localparam int unsigned DATA_W = 32;  // Width of one data word.
  localparam int unsigned BE_W   = 4;   // Bytes per data word.
  localparam int unsigned ADDR_W = 16;  // Width of a byte address.

  // One data word as seen on every channel and bank.
  typedef logic [DATA_W-1:0] data_t;

  // One enable bit per byte lane.
  typedef logic [BE_W-1:0] be_t;

  // Byte address. The low bits select the byte inside a word.
  typedef logic [ADDR_W-1:0] addr_t;

endpackage

// ==== tcdm_proto_pkg.sv ====
// Protocol package for the shared-memory cluster slice.
// Encodes the wen operation and the crossbar's per-bank owner record.
package tcdm_proto_pkg;

  // Operation carried on wen; a low wen writes.
  typedef enum logic {
    MEM_WRITE = 1'b0,
    MEM_READ  = 1'b1
  } mem_op_e;

  // Which initiator port a bank served in the previous cycle.
  typedef enum logic [1:0] {
    OWN_NONE  = 2'd0,
    OWN_PORT0 = 2'd1,
    OWN_PORT1 = 2'd2
  } owner_e;

endpackage

// ==== tcdm_mux_dynamic.sv ====
// Dynamic round-robin multiplexer that funnels memory channels into fewer initiator ports.
// Port i serves channels i, i+NB_OUT_CHAN and so on; read data comes back one cycle later.
`timescale 1ns/1ns

module tcdm_mux_dynamic
  import tcdm_mem_pkg::*;
#(
  parameter int unsigned NB_IN_CHAN  = 4,
  parameter int unsigned NB_OUT_CHAN = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,

  input  logic  [NB_IN_CHAN-1:0]   in_req,
  input  addr_t [NB_IN_CHAN-1:0]   in_add,
  input  logic  [NB_IN_CHAN-1:0]   in_wen,
  input  be_t   [NB_IN_CHAN-1:0]   in_be,
  input  data_t [NB_IN_CHAN-1:0]   in_data,
  output logic  [NB_IN_CHAN-1:0]   in_gnt,
  output data_t [NB_IN_CHAN-1:0]   in_r_data,
  output logic  [NB_IN_CHAN-1:0]   in_r_valid,

  output logic  [NB_OUT_CHAN-1:0]  out_req,
  output addr_t [NB_OUT_CHAN-1:0]  out_add,
  output logic  [NB_OUT_CHAN-1:0]  out_wen,
  output be_t   [NB_OUT_CHAN-1:0]  out_be,
  output data_t [NB_OUT_CHAN-1:0]  out_data,
  input  logic  [NB_OUT_CHAN-1:0]  out_gnt,
  input  data_t [NB_OUT_CHAN-1:0]  out_r_data,
  input  logic  [NB_OUT_CHAN-1:0]  out_r_valid
);

  localparam int unsigned NB_GRP = NB_IN_CHAN / NB_OUT_CHAN;  // Channels per output port.
  localparam int unsigned CNT_W  = (NB_GRP > 1) ? $clog2(NB_GRP) : 1;

  logic [CNT_W-1:0]                   rr_counter;   // Current top-priority slot.
  logic                               rr_advance;
  logic [NB_OUT_CHAN-1:0][CNT_W-1:0]  winner_d;     // Slot chosen this cycle per port.
  logic [NB_OUT_CHAN-1:0][CNT_W-1:0]  winner_q;     // Slot accepted in the previous cycle.
  logic [NB_OUT_CHAN-1:0]             out_req_q;    // Port had a request accepted last cycle.

  // Rotate only while somebody is served and somebody else is left waiting.
  assign rr_advance = (|(out_req & out_gnt)) & (|(in_req & ~in_gnt));

  always_ff @(posedge clk_i or negedge rst_ni) begin : rr_cnt
    if (!rst_ni) begin
      rr_counter <= '0;
    end else if (clear_i) begin
      rr_counter <= '0;
    end else if (rr_advance) begin
      if (rr_counter == CNT_W'(NB_GRP - 1)) begin
        rr_counter <= '0;  // Wrap after the last slot.
      end else begin
        rr_counter <= rr_counter + 1'b1;
      end
    end
  end

  // Rotating priority encoder. The search for port i starts at rr_counter + i.
  always_comb begin : winner_sel
    int unsigned slot;
    logic        found;
    slot     = 0;
    found    = 1'b0;
    winner_d = '0;
    out_req  = '0;
    for (int unsigned i = 0; i < NB_OUT_CHAN; i++) begin
      found = 1'b0;
      for (int unsigned j = 0; j < NB_GRP; j++) begin
        slot = (int'(rr_counter) + i + j) % NB_GRP;
        if (!found && in_req[slot*NB_OUT_CHAN+i]) begin
          winner_d[i] = CNT_W'(slot);  // First requester in priority order.
          found       = 1'b1;
        end
      end
      out_req[i] = found;
    end
  end

  // Forward the winner's request fields to its port.
  always_comb begin : field_mux
    int unsigned ch;
    ch = 0;
    for (int unsigned i = 0; i < NB_OUT_CHAN; i++) begin
      ch          = winner_d[i] * NB_OUT_CHAN + i;
      out_add[i]  = in_add[ch];
      out_wen[i]  = in_wen[ch];
      out_be[i]   = in_be[ch];
      out_data[i] = in_data[ch];
    end
  end

  // Grant goes to this cycle's winner, the response to last cycle's one.
  always_comb begin : resp_demux
    int unsigned ch_d;
    int unsigned ch_q;
    ch_d       = 0;
    ch_q       = 0;
    in_gnt     = '0;
    in_r_valid = '0;
    in_r_data  = '0;
    for (int unsigned i = 0; i < NB_OUT_CHAN; i++) begin
      for (int unsigned j = 0; j < NB_GRP; j++) begin
        in_r_data[j*NB_OUT_CHAN+i] = out_r_data[i];  // Data is shared and valid selects.
      end
      ch_d             = winner_d[i] * NB_OUT_CHAN + i;
      ch_q             = winner_q[i] * NB_OUT_CHAN + i;
      in_gnt[ch_d]     = out_gnt[i];
      in_r_valid[ch_q] = out_r_valid[i] & out_req_q[i];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : resp_track
    if (!rst_ni) begin
      winner_q  <= '0;
      out_req_q <= '0;
    end else if (clear_i) begin
      winner_q  <= '0;
      out_req_q <= '0;
    end else begin
      winner_q  <= winner_d;
      out_req_q <= out_req & out_gnt;  // Only accepted requests can answer.
    end
  end

endmodule

// ==== tcdm_bank_xbar.sv ====
// Word-interleaved crossbar between the initiator ports and the SRAM banks.
// Contested banks alternate priority and read data is routed back one cycle later.
`timescale 1ns/1ns

module tcdm_bank_xbar
  import tcdm_mem_pkg::*;
  import tcdm_proto_pkg::*;
#(
  parameter int unsigned NB_OUT_CHAN = 2,
  parameter int unsigned NB_BANKS    = 2,
  parameter int unsigned BANK_WORDS  = 64
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,

  input  logic  [NB_OUT_CHAN-1:0]                port_req,
  input  addr_t [NB_OUT_CHAN-1:0]                port_add,
  input  logic  [NB_OUT_CHAN-1:0]                port_wen,
  input  be_t   [NB_OUT_CHAN-1:0]                port_be,
  input  data_t [NB_OUT_CHAN-1:0]                port_data,
  output logic  [NB_OUT_CHAN-1:0]                port_gnt,
  output data_t [NB_OUT_CHAN-1:0]                port_r_data,
  output logic  [NB_OUT_CHAN-1:0]                port_r_valid,

  output logic  [NB_BANKS-1:0]                   bank_req,
  output logic  [NB_BANKS-1:0][$clog2(BANK_WORDS)-1:0] bank_widx,
  output logic  [NB_BANKS-1:0]                   bank_wen,
  output be_t   [NB_BANKS-1:0]                   bank_be,
  output data_t [NB_BANKS-1:0]                   bank_wdata,
  input  data_t [NB_BANKS-1:0]                   bank_rdata
);

  localparam int unsigned BOFF   = $clog2(BE_W);  // Byte offset bits inside a word.
  localparam int unsigned BSEL_W = (NB_BANKS > 1) ? $clog2(NB_BANKS) : 1;
  localparam int unsigned WIDX_W = $clog2(BANK_WORDS);

  logic [NB_OUT_CHAN-1:0][BSEL_W-1:0] port_bank;
  logic [NB_OUT_CHAN-1:0][WIDX_W-1:0] port_widx;
  logic [NB_BANKS-1:0]                win_port;  // Port that owns each bank this cycle.
  logic [NB_BANKS-1:0]                contest;   // Both ports target the bank.
  logic [NB_BANKS-1:0]                prio_q;    // Port favoured in the next contest.
  logic [NB_BANKS-1:0]                rd_q;      // Bank performs a read this cycle.
  owner_e                             owner_d [NB_BANKS];
  owner_e                             owner_q [NB_BANKS];

  // Consecutive words land in consecutive banks.
  always_comb begin : addr_decode
    logic [ADDR_W-BOFF-1:0] word;
    word = '0;
    for (int unsigned p = 0; p < NB_OUT_CHAN; p++) begin
      word         = port_add[p][ADDR_W-1:BOFF];
      port_bank[p] = BSEL_W'(word % NB_BANKS);
      port_widx[p] = WIDX_W'(word / NB_BANKS);
    end
  end

  always_comb begin : bank_arb
    logic [1:0] hit;
    hit = '0;
    for (int unsigned b = 0; b < NB_BANKS; b++) begin
      hit = '0;
      for (int unsigned p = 0; p < NB_OUT_CHAN; p++) begin
        hit[p] = port_req[p] && (port_bank[p] == BSEL_W'(b));
      end
      contest[b]  = &hit;
      win_port[b] = contest[b] ? prio_q[b] : hit[1];
      if (hit == 2'b00) begin
        owner_d[b] = OWN_NONE;
      end else begin
        owner_d[b] = win_port[b] ? OWN_PORT1 : OWN_PORT0;
      end
    end
  end

  always_comb begin : bank_drive
    for (int unsigned b = 0; b < NB_BANKS; b++) begin
      bank_req[b]   = (owner_d[b] != OWN_NONE);
      bank_widx[b]  = port_widx[win_port[b]];
      bank_wen[b]   = port_wen[win_port[b]];
      bank_be[b]    = port_be[win_port[b]];
      bank_wdata[b] = port_data[win_port[b]];
    end
  end

  // Grants follow this cycle's arbitration, responses follow last cycle's owner.
  always_comb begin : port_resp
    logic idx;
    idx          = 1'b0;
    port_gnt     = '0;
    port_r_valid = '0;
    port_r_data  = '0;
    for (int unsigned b = 0; b < NB_BANKS; b++) begin
      if (owner_d[b] != OWN_NONE) begin
        port_gnt[win_port[b]] = 1'b1;
      end
      idx = (owner_q[b] == OWN_PORT1);
      if (rd_q[b]) begin
        port_r_valid[idx] = 1'b1;
        port_r_data[idx]  = bank_rdata[b];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : bank_state
    if (!rst_ni) begin
      for (int unsigned b = 0; b < NB_BANKS; b++) begin
        owner_q[b] <= OWN_NONE;
      end
      prio_q <= '0;
      rd_q   <= '0;
    end else begin
      for (int unsigned b = 0; b < NB_BANKS; b++) begin
        owner_q[b] <= owner_d[b];
        rd_q[b]    <= bank_req[b] && (bank_wen[b] == MEM_READ);
        if (contest[b]) begin
          prio_q[b] <= ~win_port[b];  // The loser wins the next contest.
        end
      end
    end
  end

endmodule

// ==== tcdm_sram_bank.sv ====
// Single-ported SRAM bank with byte-enable writes.
// A read presents the addressed word one cycle after the request.
`timescale 1ns/1ns

module tcdm_sram_bank
  import tcdm_mem_pkg::*;
  import tcdm_proto_pkg::*;
#(
  parameter int unsigned BANK_WORDS = 64
) (
  input  logic                          clk_i,
  input  logic                          req,
  input  logic [$clog2(BANK_WORDS)-1:0] widx,
  input  logic                          wen,
  input  be_t                           be,
  input  data_t                         wdata,
  output data_t                         rdata
);

  data_t mem [BANK_WORDS];  // Word storage.

  always_ff @(posedge clk_i) begin : mem_access
    if (req) begin
      if (wen == MEM_WRITE) begin
        for (int unsigned k = 0; k < BE_W; k++) begin
          if (be[k]) begin
            mem[widx][8*k +: 8] <= wdata[8*k +: 8];  // Only enabled lanes change.
          end
        end
      end else begin
        rdata <= mem[widx];  // Holds until the next read.
      end
    end
  end

endmodule

// ==== tcdm_subsystem.sv ====
// Shared-memory cluster slice top level.
// Channels go through the round-robin mux and the bank crossbar into the SRAM banks.
`timescale 1ns/1ns

module tcdm_subsystem
  import tcdm_mem_pkg::*;
#(
  parameter int unsigned NB_IN_CHAN  = 4,
  parameter int unsigned NB_OUT_CHAN = 2,
  parameter int unsigned NB_BANKS    = 2,
  parameter int unsigned BANK_WORDS  = 64
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,

  input  logic  [NB_IN_CHAN-1:0]   in_req,
  input  addr_t [NB_IN_CHAN-1:0]   in_add,
  input  logic  [NB_IN_CHAN-1:0]   in_wen,
  input  be_t   [NB_IN_CHAN-1:0]   in_be,
  input  data_t [NB_IN_CHAN-1:0]   in_data,
  output logic  [NB_IN_CHAN-1:0]   in_gnt,
  output data_t [NB_IN_CHAN-1:0]   in_r_data,
  output logic  [NB_IN_CHAN-1:0]   in_r_valid
);

  // Mux to crossbar.
  logic  [NB_OUT_CHAN-1:0] port_req;
  addr_t [NB_OUT_CHAN-1:0] port_add;
  logic  [NB_OUT_CHAN-1:0] port_wen;
  be_t   [NB_OUT_CHAN-1:0] port_be;
  data_t [NB_OUT_CHAN-1:0] port_data;
  logic  [NB_OUT_CHAN-1:0] port_gnt;
  data_t [NB_OUT_CHAN-1:0] port_r_data;
  logic  [NB_OUT_CHAN-1:0] port_r_valid;

  // Crossbar to banks.
  logic  [NB_BANKS-1:0]                         bank_req;
  logic  [NB_BANKS-1:0][$clog2(BANK_WORDS)-1:0] bank_widx;
  logic  [NB_BANKS-1:0]                         bank_wen;
  be_t   [NB_BANKS-1:0]                         bank_be;
  data_t [NB_BANKS-1:0]                         bank_wdata;
  data_t [NB_BANKS-1:0]                         bank_rdata;

  tcdm_mux_dynamic #(
    .NB_IN_CHAN  (NB_IN_CHAN),
    .NB_OUT_CHAN (NB_OUT_CHAN)
  ) i_mux (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .in_req      (in_req),
    .in_add      (in_add),
    .in_wen      (in_wen),
    .in_be       (in_be),
    .in_data     (in_data),
    .in_gnt      (in_gnt),
    .in_r_data   (in_r_data),
    .in_r_valid  (in_r_valid),
    .out_req     (port_req),
    .out_add     (port_add),
    .out_wen     (port_wen),
    .out_be      (port_be),
    .out_data    (port_data),
    .out_gnt     (port_gnt),
    .out_r_data  (port_r_data),
    .out_r_valid (port_r_valid)
  );

  tcdm_bank_xbar #(
    .NB_OUT_CHAN  (NB_OUT_CHAN),
    .NB_BANKS     (NB_BANKS),
    .BANK_WORDS   (BANK_WORDS)
  ) i_xbar (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .port_req     (port_req),
    .port_add     (port_add),
    .port_wen     (port_wen),
    .port_be      (port_be),
    .port_data    (port_data),
    .port_gnt     (port_gnt),
    .port_r_data  (port_r_data),
    .port_r_valid (port_r_valid),
    .bank_req     (bank_req),
    .bank_widx    (bank_widx),
    .bank_wen     (bank_wen),
    .bank_be      (bank_be),
    .bank_wdata   (bank_wdata),
    .bank_rdata   (bank_rdata)
  );

  for (genvar b = 0; b < NB_BANKS; b++) begin : gen_bank
    tcdm_sram_bank #(
      .BANK_WORDS (BANK_WORDS)
    ) i_bank (
      .clk_i (clk_i),
      .req   (bank_req[b]),
      .widx  (bank_widx[b]),
      .wen   (bank_wen[b]),
      .be    (bank_be[b]),
      .wdata (bank_wdata[b]),
      .rdata (bank_rdata[b])
    );
  end

endmodule

// ==== tb_clock_gen.sv ====
// Testbench clock and reset generator.
// Reset is held low for the first two clock cycles.
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int unsigned PERIOD = 100
) (
  output logic clk_i,
  output logic rst_ni
);

  initial begin : clk_gen
    clk_i = 1'b0;
    forever #(PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin : rst_gen
    rst_ni = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;  // Released on a falling edge like every other input.
  end

endmodule

// ==== tb_tcdm_subsystem.sv ====
// Testbench for the shared-memory cluster slice.
// Applies a request table to the channels and checks reads against a byte-level model.
`timescale 1ns/1ns

module tb_tcdm_subsystem
  import tcdm_mem_pkg::*;
  import tcdm_proto_pkg::*;
();

  localparam int unsigned NB_IN_CHAN  = 4;
  localparam int unsigned NB_OUT_CHAN = 2;
  localparam int unsigned NB_BANKS    = 2;
  localparam int unsigned BANK_WORDS  = 64;
  localparam int unsigned NB_GRP      = NB_IN_CHAN / NB_OUT_CHAN;
  localparam int unsigned WORDS       = NB_BANKS * BANK_WORDS;
  localparam int unsigned MAX_ROWS    = 80;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    clear_i;
  logic  [NB_IN_CHAN-1:0]  in_req;
  addr_t [NB_IN_CHAN-1:0]  in_add;
  logic  [NB_IN_CHAN-1:0]  in_wen;
  be_t   [NB_IN_CHAN-1:0]  in_be;
  data_t [NB_IN_CHAN-1:0]  in_data;
  logic  [NB_IN_CHAN-1:0]  in_gnt;
  data_t [NB_IN_CHAN-1:0]  in_r_data;
  logic  [NB_IN_CHAN-1:0]  in_r_valid;

  logic [NB_IN_CHAN-1:0] row_mask  [MAX_ROWS];
  logic                  row_clear [MAX_ROWS];  // Pulse clear_i before the row starts.
  int unsigned           row_burst [MAX_ROWS];  // Back-to-back requests per channel.
  mem_op_e               row_op    [MAX_ROWS][NB_IN_CHAN];
  addr_t                 row_addr  [MAX_ROWS][NB_IN_CHAN];
  be_t                   row_be    [MAX_ROWS][NB_IN_CHAN];
  data_t                 row_data  [MAX_ROWS][NB_IN_CHAN];
  int unsigned           n_rows;
  int unsigned           n_slots;
  logic [7:0]            ref_mem   [WORDS*BE_W];  // Reference memory, one entry per byte.
  logic [NB_IN_CHAN-1:0] exp_valid;               // Reads accepted at the last rising edge.
  data_t                 exp_data  [NB_IN_CHAN];
  int unsigned           passed_over [NB_IN_CHAN];
  int unsigned           cycles;
  int unsigned           cycle_limit;
  int                    seed = 1615;

  tb_clock_gen #(.PERIOD (100)) i_clk_gen (.clk_i (clk_i), .rst_ni (rst_ni));

  tcdm_subsystem #(
    .NB_IN_CHAN  (NB_IN_CHAN),
    .NB_OUT_CHAN (NB_OUT_CHAN),
    .NB_BANKS    (NB_BANKS),
    .BANK_WORDS  (BANK_WORDS)
  ) uut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (clear_i),
    .in_req     (in_req),
    .in_add     (in_add),
    .in_wen     (in_wen),
    .in_be      (in_be),
    .in_data    (in_data),
    .in_gnt     (in_gnt),
    .in_r_data  (in_r_data),
    .in_r_valid (in_r_valid)
  );

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_valid(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  // Advance to the next falling edge and check the responses of the last accepts.
  task automatic next_cycle();
    @(negedge clk_i);
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the request table did not complete", cycles);
      abort_run();
    end
    for (int unsigned c = 0; c < NB_IN_CHAN; c++) begin
      check_valid($sformatf("in_r_valid[%0d]", c), in_r_valid[c], exp_valid[c]);
      if (exp_valid[c]) begin
        check_data($sformatf("in_r_data[%0d]", c), in_r_data[c], exp_data[c]);
      end
    end
    exp_valid = '0;
  endtask

  // Update the model in acceptance order; a read sees the word as it is now.
  task automatic record_accept(input int unsigned c);
    int unsigned base;
    base = in_add[c];
    base = (base / BE_W) * BE_W;
    for (int unsigned k = 0; k < BE_W; k++) begin
      if (in_wen[c] == MEM_WRITE && in_be[c][k]) begin
        ref_mem[base+k] = in_data[c][8*k +: 8];
      end
      exp_data[c][8*k +: 8] = ref_mem[base+k];
    end
    exp_valid[c] = (in_wen[c] == MEM_READ);
  endtask

  // A waiting channel may see at most NB_GRP-1 other accepts on its mux port.
  task automatic count_passed_over(input int unsigned a);
    passed_over[a] = 0;
    for (int unsigned c = 0; c < NB_IN_CHAN; c++) begin
      if (c != a && (c % NB_OUT_CHAN) == (a % NB_OUT_CHAN) && in_req[c] && !in_gnt[c]) begin
        passed_over[c]++;
        if (passed_over[c] >= NB_GRP) begin
          $display("Channel %0d starved through %0d accepts of its port", c, passed_over[c]);
          abort_run();
        end
      end
    end
  endtask

  task automatic apply_row(input int unsigned r);
    int unsigned           sent [NB_IN_CHAN];
    logic [NB_IN_CHAN-1:0] busy;
    logic [NB_BANKS-1:0]   bank_used;
    int unsigned           bank;
    busy      = row_mask[r];
    bank_used = '0;
    bank      = 0;
    for (int unsigned c = 0; c < NB_IN_CHAN; c++) begin
      sent[c] = 0;
    end
    if (row_clear[r]) begin
      next_cycle();
      in_req  = '0;
      clear_i = 1'b1;
      next_cycle();
      clear_i = 1'b0;
    end
    while (busy != '0) begin
      next_cycle();
      for (int unsigned c = 0; c < NB_IN_CHAN; c++) begin
        in_req[c]  = busy[c];  // Held with the same fields until granted.
        in_add[c]  = row_addr[r][c] + addr_t'(sent[c] * BE_W);
        in_wen[c]  = row_op[r][c];
        in_be[c]   = row_be[r][c];
        in_data[c] = row_data[r][c] + data_t'(sent[c]);
      end
      #1;
      if ((in_gnt & ~in_req) != '0) begin
        $display("A channel was granted without a request");
        abort_run();
      end
      bank_used = '0;
      for (int unsigned c = 0; c < NB_IN_CHAN; c++) begin
        if (in_req[c] && in_gnt[c]) begin
          bank = (int'(in_add[c]) / BE_W) % NB_BANKS;
          if (bank_used[bank]) begin
            $display("Bank %0d accepted two requests in one cycle", bank);
            abort_run();
          end
          bank_used[bank] = 1'b1;
          record_accept(c);
          count_passed_over(c);
          sent[c]++;
          if (sent[c] == row_burst[r]) begin
            busy[c] = 1'b0;
          end
        end
      end
    end
  endtask

  task automatic new_row(input logic [NB_IN_CHAN-1:0] mask, input int unsigned burst,
                         input logic clr);
    row_mask[n_rows]  = mask;
    row_burst[n_rows] = burst;
    row_clear[n_rows] = clr;
    for (int unsigned c = 0; c < NB_IN_CHAN; c++) begin
      row_op[n_rows][c]   = MEM_READ;
      row_addr[n_rows][c] = '0;
      row_be[n_rows][c]   = '0;
      row_data[n_rows][c] = '0;
    end
    n_slots += burst + (clr ? 2 : 0);
    n_rows++;
  endtask

  task automatic set_req(input int unsigned c, input mem_op_e op, input int unsigned a,
                         input be_t be, input data_t d);
    row_op[n_rows-1][c]   = op;
    row_addr[n_rows-1][c] = addr_t'(a);
    row_be[n_rows-1][c]   = be;
    row_data[n_rows-1][c] = d;
  endtask

  task automatic build_table();
    int unsigned a;
    int unsigned base;
    a       = 0;
    base    = 0;
    n_rows  = 0;
    n_slots = 0;
    for (int unsigned w = 0; w < WORDS; w += NB_IN_CHAN) begin
      new_row('1, 1, 1'b0);
      for (int unsigned c = 0; c < NB_IN_CHAN; c++) begin
        a = (w + c) * BE_W;
        set_req(c, MEM_WRITE, a, '1, {~addr_t'(a), addr_t'(a)});  // Fill tied to address.
      end
    end
    new_row('0, 0, 1'b1);
    new_row(4'b0001, 1, 1'b0);
    set_req(0, MEM_WRITE, 'h40, '1, data_t'($random(seed)));
    new_row(4'b0001, 1, 1'b0);
    set_req(0, MEM_READ, 'h40, '1, '0);
    new_row(4'b0010, 1, 1'b0);
    set_req(1, MEM_WRITE, 'h84, 4'b0101, data_t'($random(seed)));
    new_row(4'b0010, 1, 1'b0);
    set_req(1, MEM_READ, 'h84, '1, '0);
    new_row(4'b1000, 1, 1'b0);
    set_req(3, MEM_WRITE, 'h84, 4'b1000, data_t'($random(seed)));
    new_row(4'b0010, 1, 1'b0);
    set_req(1, MEM_READ, 'h84, '1, '0);
    new_row(4'b0101, 6, 1'b0);  // Both channels of port 0 stream reads.
    set_req(0, MEM_READ, 'h100, '1, '0);
    set_req(2, MEM_READ, 'h180, '1, '0);
    new_row(4'b0011, 1, 1'b0);  // Port 0 and port 1 both target bank 0.
    set_req(0, MEM_WRITE, 'h10, '1, data_t'($random(seed)));
    set_req(1, MEM_WRITE, 'h18, '1, data_t'($random(seed)));
    new_row(4'b0011, 1, 1'b0);
    set_req(0, MEM_READ, 'h18, '1, '0);
    set_req(1, MEM_READ, 'h10, '1, '0);
    for (int unsigned i = 0; i < 24; i++) begin
      new_row(NB_IN_CHAN'($random(seed)) | NB_IN_CHAN'(1), 1, 1'b0);
      base = $unsigned($random(seed)) % WORDS;
      for (int unsigned c = 0; c < NB_IN_CHAN; c++) begin
        a = ((base + c * 37) % WORDS) * BE_W;  // Distinct words inside the row.
        set_req(c, mem_op_e'(1'($random(seed))), a, be_t'($random(seed)),
                data_t'($random(seed)));
      end
    end
  endtask

  initial begin : run
    clear_i   = 1'b0;
    in_req    = '0;
    in_add    = '0;
    in_wen    = '0;
    in_be     = '0;
    in_data   = '0;
    exp_valid = '0;
    cycles    = 0;
    for (int unsigned c = 0; c < NB_IN_CHAN; c++) begin
      passed_over[c] = 0;
    end
    build_table();
    cycle_limit = (n_slots + 2) * NB_IN_CHAN * 8;
    wait (rst_ni === 1'b1);
    repeat (3) next_cycle();
    for (int unsigned r = 0; r < n_rows; r++) begin
      apply_row(r);
    end
    next_cycle();
    in_req = '0;
    repeat (2) next_cycle();
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== sim.f ====
tcdm_mem_pkg.sv
tcdm_proto_pkg.sv
tcdm_mux_dynamic.sv
tcdm_bank_xbar.sv
tcdm_sram_bank.sv
tcdm_subsystem.sv
tb_clock_gen.sv
tb_tcdm_subsystem.sv

// ==== Makefile ====
# Verilator build and run of the shared-memory cluster slice testbench.

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ns -f sim.f \
	  --top-module tb_tcdm_subsystem -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_tcdm_subsystem)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir
